// File: files.f
id_pkg.sv
inst_decoder.sv
operand_select.sv
branch_unit.sv
regfile.sv
id_ex_reg.sv
id_stage.sv
tb_id_stage.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module tb_id_stage -o sim_tb

# the log decides pass or fail
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

grep -qx "TEST OK" sim.log

// File: tb_id_stage.sv
`timescale 1ns/1ns

module tb_id_stage;

  logic        clk = 1'b0;
  logic        rst_i;
  logic        inst_valid_i;
  logic [31:0] pc_i, inst_i;
  logic        ex_wreg_i, mem_wreg_i, wb_we_i;
  logic [4:0]  ex_wd_i, mem_wd_i, wb_waddr_i;
  logic [31:0] ex_wdata_i, mem_wdata_i, wb_wdata_i;

  logic            stall_o, branch_flag_o, ex_valid_o, ex_wreg_o;
  logic            ex_in_delayslot_o, ex_invalid_o;
  logic [31:0]     branch_addr_o, ex_reg1_o, ex_reg2_o, ex_link_addr_o, ex_inst_o;
  logic [4:0]      ex_wd_o;
  id_pkg::aluop_t  ex_aluop_o;
  id_pkg::alusel_t ex_alusel_o;

  // shadow copy of the register file
  logic [31:0] shadow [32];
  int          seed;
  int          stall_cycles;
  logic        seen_flag;
  logic [31:0] seen_addr;
  logic [31:0] wb_val;

  id_stage id_stage_i (.*);

  always #4 clk = ~clk;

  function automatic logic [31:0] r_word(logic [5:0] fn, logic [4:0] rs, logic [4:0] rt,
                                         logic [4:0] rd, logic [4:0] sa);
    return {6'b000000, rs, rt, rd, sa, fn};
  endfunction

  function automatic logic [31:0] i_word(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                         logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("TEST FAILED");
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      $fatal(1);
    end
  endtask

  task automatic stop_with(input string msg);
    $display("TEST FAILED");
    $display("%s", msg);
    $fatal(1);
  endtask

  task automatic check_decode(input id_pkg::aluop_t op, input id_pkg::alusel_t sel,
                              input logic [4:0] wd, input logic wreg);
    check_value("ex_valid_o", 32'(ex_valid_o), 32'h1);
    check_value("ex_aluop_o", 32'(ex_aluop_o), 32'(op));
    check_value("ex_alusel_o", 32'(ex_alusel_o), 32'(sel));
    check_value("ex_wd_o", 32'(ex_wd_o), 32'(wd));
    check_value("ex_wreg_o", 32'(ex_wreg_o), 32'(wreg));
    check_value("ex_invalid_o", 32'(ex_invalid_o), 32'h0);
  endtask

  task automatic check_ops(input logic [31:0] exp1, input logic [31:0] exp2);
    check_value("ex_reg1_o", ex_reg1_o, exp1);
    check_value("ex_reg2_o", ex_reg2_o, exp2);
  endtask

  task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
    wb_we_i    = 1'b1;
    wb_waddr_i = addr;
    wb_wdata_i = data;
    @(posedge clk);
    #1;
    wb_we_i = 1'b0;
    if (addr != 5'd0) begin
      shadow[addr] = data;
    end
  endtask

  // present one instruction and wait until the stage takes it
  task automatic send(input logic [31:0] pc, input logic [31:0] inst);
    inst_valid_i = 1'b1;
    pc_i         = pc;
    inst_i       = inst;
    stall_cycles = 0;
    #3;
    while (stall_o) begin
      stall_cycles++;
      if (stall_cycles > 16) begin
        stop_with("timeout: instruction was never accepted by the stage");
      end
      @(posedge clk);
      #4;
      // a stalled cycle loads a bubble
      check_value("ex_valid_o", 32'(ex_valid_o), 32'h0);
    end
    seen_flag = branch_flag_o;
    seen_addr = branch_addr_o;
    @(posedge clk);
    #1;
    check_value("ex_inst_o", ex_inst_o, inst);
    inst_valid_i = 1'b0;
    wb_we_i      = 1'b0;
    ex_wreg_i    = 1'b0;
    mem_wreg_i   = 1'b0;
  endtask

  // two plain ori after a jump or branch
  task automatic check_delay_slot(input logic exp_first);
    send(32'h0000_0400, i_word(6'h0d, 5'd0, 5'd20, 16'h0001));
    check_value("ex_in_delayslot_o", 32'(ex_in_delayslot_o), 32'(exp_first));
    send(32'h0000_0404, i_word(6'h0d, 5'd0, 5'd21, 16'h0002));
    check_value("ex_in_delayslot_o", 32'(ex_in_delayslot_o), 32'h0);
  endtask

  initial begin
    seed         = 32'h8b35_464b;
    rst_i        = 1'b1;
    inst_valid_i = 1'b0;
    pc_i         = 32'h0;
    inst_i       = 32'h0;
    ex_wreg_i    = 1'b0;
    ex_wd_i      = 5'd0;
    ex_wdata_i   = 32'h0;
    mem_wreg_i   = 1'b0;
    mem_wd_i     = 5'd0;
    mem_wdata_i  = 32'h0;
    wb_we_i      = 1'b0;
    wb_waddr_i   = 5'd0;
    wb_wdata_i   = 32'h0;
    for (int k = 0; k < 32; k++) begin
      shadow[k] = 32'h0;
    end
    repeat (5) @(posedge clk);
    #1;
    rst_i = 1'b0;
    check_value("ex_valid_o", 32'(ex_valid_o), 32'h0);
    check_value("ex_wreg_o", 32'(ex_wreg_o), 32'h0);
    check_value("stall_o", 32'(stall_o), 32'h0);
    check_value("branch_flag_o", 32'(branch_flag_o), 32'h0);
    check_value("ex_in_delayslot_o", 32'(ex_in_delayslot_o), 32'h0);

    for (int k = 1; k < 32; k++) begin
      write_reg(5'(k), $random(seed));
    end

    // decode: addu, sub, sll, ori, lui, addiu, slti, lw
    send(32'h0040_0000, r_word(6'h21, 5'd1, 5'd2, 5'd3, 5'd0));
    check_decode(id_pkg::ALU_ADDU, id_pkg::SEL_ARITH, 5'd3, 1'b1);
    check_ops(shadow[1], shadow[2]);
    send(32'h0040_0004, r_word(6'h22, 5'd3, 5'd4, 5'd5, 5'd0));
    check_decode(id_pkg::ALU_SUB, id_pkg::SEL_ARITH, 5'd5, 1'b1);
    check_ops(shadow[3], shadow[4]);
    send(32'h0040_0008, r_word(6'h00, 5'd0, 5'd5, 5'd6, 5'd7));
    check_decode(id_pkg::ALU_SLL, id_pkg::SEL_SHIFT, 5'd6, 1'b1);
    check_ops(32'd7, shadow[5]);
    send(32'h0040_000c, i_word(6'h0d, 5'd8, 5'd9, 16'ha5f0));
    check_decode(id_pkg::ALU_OR, id_pkg::SEL_LOGIC, 5'd9, 1'b1);
    check_ops(shadow[8], 32'h0000_a5f0);
    send(32'h0040_0010, i_word(6'h0f, 5'd0, 5'd10, 16'h1234));
    check_decode(id_pkg::ALU_OR, id_pkg::SEL_LOGIC, 5'd10, 1'b1);
    check_ops(32'h0, 32'h1234_0000);
    send(32'h0040_0014, i_word(6'h09, 5'd11, 5'd12, 16'h8004));
    check_decode(id_pkg::ALU_ADDIU, id_pkg::SEL_ARITH, 5'd12, 1'b1);
    check_ops(shadow[11], 32'hffff_8004);
    send(32'h0040_0018, i_word(6'h0a, 5'd13, 5'd14, 16'hfff0));
    check_decode(id_pkg::ALU_SLT, id_pkg::SEL_ARITH, 5'd14, 1'b1);
    check_ops(shadow[13], 32'hffff_fff0);
    send(32'h0040_001c, i_word(6'h23, 5'd15, 5'd16, 16'h0010));
    check_decode(id_pkg::ALU_LW, id_pkg::SEL_LOAD_STORE, 5'd16, 1'b1);
    check_value("ex_reg1_o", ex_reg1_o, shadow[15]);

    // bypass priority, both match then mem only
    ex_wreg_i   = 1'b1;
    ex_wd_i     = 5'd1;
    ex_wdata_i  = 32'hcafe_0001;
    mem_wreg_i  = 1'b1;
    mem_wd_i    = 5'd1;
    mem_wdata_i = 32'hbeef_0001;
    send(32'h0040_0020, r_word(6'h21, 5'd1, 5'd2, 5'd3, 5'd0));
    check_ops(32'hcafe_0001, shadow[2]);
    ex_wreg_i   = 1'b1;
    ex_wd_i     = 5'd7;
    mem_wreg_i  = 1'b1;
    mem_wd_i    = 5'd2;
    mem_wdata_i = 32'hbeef_0002;
    send(32'h0040_0024, r_word(6'h21, 5'd1, 5'd2, 5'd3, 5'd0));
    check_ops(shadow[1], 32'hbeef_0002);
    // writeback in the same cycle as the read
    wb_val     = $random(seed);
    wb_we_i    = 1'b1;
    wb_waddr_i = 5'd1;
    wb_wdata_i = wb_val;
    send(32'h0040_0028, r_word(6'h21, 5'd1, 5'd2, 5'd3, 5'd0));
    shadow[1] = wb_val;
    check_ops(wb_val, shadow[2]);

    // load-use, loaded value arrives on the mem bypass
    send(32'h0040_002c, i_word(6'h23, 5'd1, 5'd9, 16'h0004));
    check_decode(id_pkg::ALU_LW, id_pkg::SEL_LOAD_STORE, 5'd9, 1'b1);
    mem_wreg_i  = 1'b1;
    mem_wd_i    = 5'd9;
    mem_wdata_i = 32'h1234_5678;
    send(32'h0040_0030, r_word(6'h21, 5'd9, 5'd2, 5'd10, 5'd0));
    check_value("stall cycles", 32'(stall_cycles), 32'd1);
    check_decode(id_pkg::ALU_ADDU, id_pkg::SEL_ARITH, 5'd10, 1'b1);
    check_ops(32'h1234_5678, shadow[2]);

    // j: top nibble of pc+4, target, two zero bits
    send(32'h1040_0200, {6'h02, 26'h012_3456});
    check_value("branch_flag_o", 32'(seen_flag), 32'h1);
    check_value("branch_addr_o", seen_addr, {4'h1, 26'h012_3456, 2'b00});
    check_delay_slot(1'b1);
    send(32'h2000_0010, {6'h03, 26'h000_0040});
    check_value("branch_flag_o", 32'(seen_flag), 32'h1);
    check_value("branch_addr_o", seen_addr, 32'h2000_0100);
    check_decode(id_pkg::ALU_JAL, id_pkg::SEL_JUMP_BRANCH, 5'd31, 1'b1);
    check_value("ex_link_addr_o", ex_link_addr_o, 32'h2000_0018);
    check_delay_slot(1'b1);
    send(32'h0040_0100, r_word(6'h08, 5'd4, 5'd0, 5'd0, 5'd0));
    check_value("branch_flag_o", 32'(seen_flag), 32'h1);
    check_value("branch_addr_o", seen_addr, shadow[4]);
    check_delay_slot(1'b1);
    // beq taken backwards, offset -4 words from pc+4
    write_reg(5'd7, shadow[5]);
    send(32'h0040_1000, i_word(6'h04, 5'd5, 5'd7, 16'hfffc));
    check_value("branch_flag_o", 32'(seen_flag), 32'h1);
    check_value("branch_addr_o", seen_addr, 32'h0040_0ff4);
    check_delay_slot(1'b1);
    write_reg(5'd6, shadow[5] ^ 32'h1);
    send(32'h0040_1100, i_word(6'h04, 5'd5, 5'd6, 16'h0008));
    check_value("branch_flag_o", 32'(seen_flag), 32'h0);
    check_delay_slot(1'b0);

    // unknown opcode
    send(32'h0040_2000, 32'hfc00_0000);
    check_value("ex_valid_o", 32'(ex_valid_o), 32'h1);
    check_value("ex_invalid_o", 32'(ex_invalid_o), 32'h1);
    check_value("ex_wreg_o", 32'(ex_wreg_o), 32'h0);

    $display("TEST OK");
    $finish;
  end

endmodule

// File: id_stage.sv
`timescale 1ns/1ns

module id_stage #(
  parameter int DATA_W     = id_pkg::DATA_W,
  parameter int REG_ADDR_W = id_pkg::REG_ADDR_W
) (
  input  logic                  clk,
  input  logic                  rst_i,
  input  logic                  inst_valid_i,
  input  logic [DATA_W-1:0]     pc_i,
  input  logic [DATA_W-1:0]     inst_i,
  // bypass from execute and memory
  input  logic                  ex_wreg_i,
  input  logic [REG_ADDR_W-1:0] ex_wd_i,
  input  logic [DATA_W-1:0]     ex_wdata_i,
  input  logic                  mem_wreg_i,
  input  logic [REG_ADDR_W-1:0] mem_wd_i,
  input  logic [DATA_W-1:0]     mem_wdata_i,
  input  logic                  wb_we_i,
  input  logic [REG_ADDR_W-1:0] wb_waddr_i,
  input  logic [DATA_W-1:0]     wb_wdata_i,
  // back to fetch
  output logic                  stall_o,
  output logic                  branch_flag_o,
  output logic [DATA_W-1:0]     branch_addr_o,
  output logic                  ex_valid_o,
  output id_pkg::aluop_t        ex_aluop_o,
  output id_pkg::alusel_t       ex_alusel_o,
  output logic [DATA_W-1:0]     ex_reg1_o,
  output logic [DATA_W-1:0]     ex_reg2_o,
  output logic [REG_ADDR_W-1:0] ex_wd_o,
  output logic                  ex_wreg_o,
  output logic [DATA_W-1:0]     ex_link_addr_o,
  output logic [DATA_W-1:0]     ex_inst_o,
  output logic                  ex_in_delayslot_o,
  output logic                  ex_invalid_o
);

  id_pkg::aluop_t        dec_aluop;
  id_pkg::alusel_t       dec_alusel;
  logic [REG_ADDR_W-1:0] dec_wd, reg1_addr, reg2_addr;
  logic                  dec_wreg, dec_invalid, reg1_read, reg2_read;
  logic [DATA_W-1:0]     imm, rf_data1, rf_data2, reg1, reg2, link_addr;
  logic                  stall1, stall2, br_flag, next_delayslot, accept, prev_load;

  // registered op is a bubble unless it was accepted
  assign prev_load     = id_pkg::is_load(ex_aluop_o);
  assign stall_o       = inst_valid_i & (stall1 | stall2);
  assign accept        = inst_valid_i & ~stall_o;
  assign branch_flag_o = br_flag & accept;

  inst_decoder u_decoder (
    .inst_i      (inst_i),      .aluop_o     (dec_aluop),   .alusel_o    (dec_alusel),
    .wd_o        (dec_wd),      .wreg_o      (dec_wreg),    .reg1_read_o (reg1_read),
    .reg2_read_o (reg2_read),   .reg1_addr_o (reg1_addr),   .reg2_addr_o (reg2_addr),
    .imm_o       (imm),         .invalid_o   (dec_invalid)
  );

  regfile #(.DATA_W(DATA_W), .REG_ADDR_W(REG_ADDR_W)) u_regfile (
    .clk      (clk),        .rst_i    (rst_i),
    .we_i     (wb_we_i),    .waddr_i  (wb_waddr_i), .wdata_i  (wb_wdata_i),
    .re1_i    (reg1_read),  .raddr1_i (reg1_addr),  .rdata1_o (rf_data1),
    .re2_i    (reg2_read),  .raddr2_i (reg2_addr),  .rdata2_o (rf_data2)
  );

  operand_select #(.DATA_W(DATA_W), .REG_ADDR_W(REG_ADDR_W)) u_opnd1 (
    .read_i      (reg1_read),  .addr_i     (reg1_addr),   .rf_data_i  (rf_data1),
    .imm_i       (imm),        .ex_wreg_i  (ex_wreg_i),   .ex_wd_i    (ex_wd_i),
    .ex_wdata_i  (ex_wdata_i), .mem_wreg_i (mem_wreg_i),  .mem_wd_i   (mem_wd_i),
    .mem_wdata_i (mem_wdata_i), .prev_load_i (prev_load), .prev_wd_i  (ex_wd_o),
    .data_o      (reg1),       .stall_o    (stall1)
  );

  operand_select #(.DATA_W(DATA_W), .REG_ADDR_W(REG_ADDR_W)) u_opnd2 (
    .read_i      (reg2_read),  .addr_i     (reg2_addr),   .rf_data_i  (rf_data2),
    .imm_i       (imm),        .ex_wreg_i  (ex_wreg_i),   .ex_wd_i    (ex_wd_i),
    .ex_wdata_i  (ex_wdata_i), .mem_wreg_i (mem_wreg_i),  .mem_wd_i   (mem_wd_i),
    .mem_wdata_i (mem_wdata_i), .prev_load_i (prev_load), .prev_wd_i  (ex_wd_o),
    .data_o      (reg2),       .stall_o    (stall2)
  );

  branch_unit u_branch (
    .pc_i          (pc_i),      .inst_i        (inst_i),     .aluop_i (dec_aluop),
    .reg1_i        (reg1),      .reg2_i        (reg2),       .branch_flag_o (br_flag),
    .branch_addr_o (branch_addr_o), .link_addr_o (link_addr),
    .next_in_delayslot_o (next_delayslot)
  );

  id_ex_reg #(.DATA_W(DATA_W), .REG_ADDR_W(REG_ADDR_W)) u_id_ex (
    .clk            (clk),            .rst_i        (rst_i),       .accept_i  (accept),
    .aluop_i        (dec_aluop),      .alusel_i     (dec_alusel),  .reg1_i    (reg1),
    .reg2_i         (reg2),           .wd_i         (dec_wd),      .wreg_i    (dec_wreg),
    .link_addr_i    (link_addr),      .inst_i       (inst_i),      .invalid_i (dec_invalid),
    .next_in_delayslot_i (next_delayslot),
    .ex_valid_o     (ex_valid_o),     .ex_aluop_o   (ex_aluop_o),  .ex_alusel_o (ex_alusel_o),
    .ex_reg1_o      (ex_reg1_o),      .ex_reg2_o    (ex_reg2_o),   .ex_wd_o   (ex_wd_o),
    .ex_wreg_o      (ex_wreg_o),      .ex_link_addr_o (ex_link_addr_o),
    .ex_inst_o      (ex_inst_o),      .ex_in_delayslot_o (ex_in_delayslot_o),
    .ex_invalid_o   (ex_invalid_o)
  );

endmodule

// File: id_ex_reg.sv
`timescale 1ns/1ns

module id_ex_reg #(
  parameter int DATA_W     = 32,
  parameter int REG_ADDR_W = 5
) (
  input  logic                  clk,
  input  logic                  rst_i,
  input  logic                  accept_i,
  input  id_pkg::aluop_t        aluop_i,
  input  id_pkg::alusel_t       alusel_i,
  input  logic [DATA_W-1:0]     reg1_i,
  input  logic [DATA_W-1:0]     reg2_i,
  input  logic [REG_ADDR_W-1:0] wd_i,
  input  logic                  wreg_i,
  input  logic [DATA_W-1:0]     link_addr_i,
  input  logic [DATA_W-1:0]     inst_i,
  input  logic                  invalid_i,
  input  logic                  next_in_delayslot_i,
  output logic                  ex_valid_o,
  output id_pkg::aluop_t        ex_aluop_o,
  output id_pkg::alusel_t       ex_alusel_o,
  output logic [DATA_W-1:0]     ex_reg1_o,
  output logic [DATA_W-1:0]     ex_reg2_o,
  output logic [REG_ADDR_W-1:0] ex_wd_o,
  output logic                  ex_wreg_o,
  output logic [DATA_W-1:0]     ex_link_addr_o,
  output logic [DATA_W-1:0]     ex_inst_o,
  output logic                  ex_in_delayslot_o,
  output logic                  ex_invalid_o
);

  // set by an accepted jump, consumed by the next accepted instruction
  logic delayslot_q;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      ex_valid_o        <= 1'b0;
      ex_aluop_o        <= id_pkg::ALU_NOP;
      ex_alusel_o       <= id_pkg::SEL_NOP;
      ex_wd_o           <= '0;
      ex_wreg_o         <= 1'b0;
      ex_in_delayslot_o <= 1'b0;
      ex_invalid_o      <= 1'b0;
      delayslot_q       <= 1'b0;
    end else if (accept_i) begin
      ex_valid_o        <= 1'b1;
      ex_aluop_o        <= aluop_i;
      ex_alusel_o       <= alusel_i;
      ex_wd_o           <= wd_i;
      ex_wreg_o         <= wreg_i;
      ex_in_delayslot_o <= delayslot_q;
      ex_invalid_o      <= invalid_i;
      delayslot_q       <= next_in_delayslot_i;
    end else begin
      // bubble, delay-slot state kept
      ex_valid_o        <= 1'b0;
      ex_aluop_o        <= id_pkg::ALU_NOP;
      ex_alusel_o       <= id_pkg::SEL_NOP;
      ex_wd_o           <= '0;
      ex_wreg_o         <= 1'b0;
      ex_in_delayslot_o <= 1'b0;
      ex_invalid_o      <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept_i) begin
      ex_reg1_o      <= reg1_i;
      ex_reg2_o      <= reg2_i;
      ex_link_addr_o <= link_addr_i;
      ex_inst_o      <= inst_i;
    end
  end

endmodule

// File: regfile.sv
`timescale 1ns/1ns

module regfile #(
  parameter int DATA_W     = 32,
  parameter int REG_ADDR_W = 5
) (
  input  logic                  clk,
  input  logic                  rst_i,
  input  logic                  we_i,
  input  logic [REG_ADDR_W-1:0] waddr_i,
  input  logic [DATA_W-1:0]     wdata_i,
  input  logic                  re1_i,
  input  logic [REG_ADDR_W-1:0] raddr1_i,
  input  logic                  re2_i,
  input  logic [REG_ADDR_W-1:0] raddr2_i,
  output logic [DATA_W-1:0]     rdata1_o,
  output logic [DATA_W-1:0]     rdata2_o
);

  logic [DATA_W-1:0] regs [id_pkg::REG_NUM];

  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int k = 0; k < id_pkg::REG_NUM; k++) begin
        regs[k] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // r0 reads zero, a same-cycle write passes through
  function automatic logic [DATA_W-1:0] read_port(logic re, logic [REG_ADDR_W-1:0] ra);
    if (!re || (ra == '0)) begin
      return '0;
    end else if (we_i && (waddr_i == ra)) begin
      return wdata_i;
    end
    return regs[ra];
  endfunction

  always_comb begin
    rdata1_o = read_port(re1_i, raddr1_i);
    rdata2_o = read_port(re2_i, raddr2_i);
  end

endmodule

// File: branch_unit.sv
`timescale 1ns/1ns

module branch_unit (
  input  logic [id_pkg::DATA_W-1:0] pc_i,
  input  id_pkg::inst_t             inst_i,
  input  id_pkg::aluop_t            aluop_i,
  input  logic [id_pkg::DATA_W-1:0] reg1_i,
  input  logic [id_pkg::DATA_W-1:0] reg2_i,
  output logic                      branch_flag_o,
  output logic [id_pkg::DATA_W-1:0] branch_addr_o,
  output logic [id_pkg::DATA_W-1:0] link_addr_o,
  output logic                      next_in_delayslot_o
);

  logic [id_pkg::DATA_W-1:0] pc_plus_4;
  logic [id_pkg::DATA_W-1:0] pc_plus_8;
  logic [id_pkg::DATA_W-1:0] br_offset;

  assign pc_plus_4 = pc_i + 32'd4;
  assign pc_plus_8 = pc_i + 32'd8;
  // word offset, sign extended
  assign br_offset = {{14{inst_i.i.imm[15]}}, inst_i.i.imm, 2'b00};

  always_comb begin
    branch_flag_o = 1'b0;
    branch_addr_o = '0;
    case (aluop_i)
      id_pkg::ALU_J,
      id_pkg::ALU_JAL: begin
        branch_flag_o = 1'b1;
        branch_addr_o = {pc_plus_4[31:28], inst_i.j.target, 2'b00};
      end
      id_pkg::ALU_JR,
      id_pkg::ALU_JALR: begin
        branch_flag_o = 1'b1;
        branch_addr_o = reg1_i;
      end
      id_pkg::ALU_BEQ: begin
        if (reg1_i == reg2_i) begin
          branch_flag_o = 1'b1;
          branch_addr_o = pc_plus_4 + br_offset;
        end
      end
      default: ;
    endcase
  end

  // return past the delay slot
  assign link_addr_o = (aluop_i inside {id_pkg::ALU_JAL, id_pkg::ALU_JALR}) ? pc_plus_8 : '0;

  assign next_in_delayslot_o = branch_flag_o;

endmodule

// File: operand_select.sv
`timescale 1ns/1ns

module operand_select #(
  parameter int DATA_W     = 32,
  parameter int REG_ADDR_W = 5
) (
  input  logic                  read_i,
  input  logic [REG_ADDR_W-1:0] addr_i,
  input  logic [DATA_W-1:0]     rf_data_i,
  input  logic [DATA_W-1:0]     imm_i,
  input  logic                  ex_wreg_i,
  input  logic [REG_ADDR_W-1:0] ex_wd_i,
  input  logic [DATA_W-1:0]     ex_wdata_i,
  input  logic                  mem_wreg_i,
  input  logic [REG_ADDR_W-1:0] mem_wd_i,
  input  logic [DATA_W-1:0]     mem_wdata_i,
  input  logic                  prev_load_i,
  input  logic [REG_ADDR_W-1:0] prev_wd_i,
  output logic [DATA_W-1:0]     data_o,
  output logic                  stall_o
);

  // load data only exists after the mem stage
  assign stall_o = read_i && prev_load_i && (prev_wd_i == addr_i);

  always_comb begin
    if (!read_i) begin
      data_o = imm_i;
    end else if (ex_wreg_i && (ex_wd_i == addr_i)) begin
      // youngest result wins
      data_o = ex_wdata_i;
    end else if (mem_wreg_i && (mem_wd_i == addr_i)) begin
      data_o = mem_wdata_i;
    end else begin
      data_o = rf_data_i;
    end
  end

endmodule

// File: inst_decoder.sv
`timescale 1ns/1ns

module inst_decoder (
  input  id_pkg::inst_t                 inst_i,
  output id_pkg::aluop_t                aluop_o,
  output id_pkg::alusel_t               alusel_o,
  output logic [id_pkg::REG_ADDR_W-1:0] wd_o,
  output logic                          wreg_o,
  output logic                          reg1_read_o,
  output logic                          reg2_read_o,
  output logic [id_pkg::REG_ADDR_W-1:0] reg1_addr_o,
  output logic [id_pkg::REG_ADDR_W-1:0] reg2_addr_o,
  output logic [id_pkg::DATA_W-1:0]     imm_o,
  output logic                          invalid_o
);

  // result class from the position of the op in aluop_t
  function automatic id_pkg::alusel_t class_of(id_pkg::aluop_t op);
    if (op == id_pkg::ALU_NOP) begin
      return id_pkg::SEL_NOP;
    end else if (op <= id_pkg::ALU_NOR) begin
      return id_pkg::SEL_LOGIC;
    end else if (op <= id_pkg::ALU_SRAV) begin
      return id_pkg::SEL_SHIFT;
    end else if (op <= id_pkg::ALU_ADDIU) begin
      return id_pkg::SEL_ARITH;
    end else if (op <= id_pkg::ALU_BEQ) begin
      return id_pkg::SEL_JUMP_BRANCH;
    end
    return id_pkg::SEL_LOAD_STORE;
  endfunction

  logic [15:0] imm;

  assign imm      = inst_i.i.imm;
  assign alusel_o = class_of(aluop_o);

  always_comb begin
    aluop_o     = id_pkg::ALU_NOP;
    wd_o        = inst_i.r.rd;
    wreg_o      = 1'b0;
    reg1_read_o = 1'b0;
    reg2_read_o = 1'b0;
    reg1_addr_o = inst_i.r.rs;
    reg2_addr_o = inst_i.r.rt;
    imm_o       = '0;
    if (inst_i.r.op == id_pkg::OP_SPECIAL) begin
      // register forms, shamt must be zero
      if (inst_i.r.shamt == '0) begin
        case (inst_i.r.funct)
          id_pkg::FN_OR:   aluop_o = id_pkg::ALU_OR;
          id_pkg::FN_AND:  aluop_o = id_pkg::ALU_AND;
          id_pkg::FN_XOR:  aluop_o = id_pkg::ALU_XOR;
          id_pkg::FN_NOR:  aluop_o = id_pkg::ALU_NOR;
          id_pkg::FN_SLLV: aluop_o = id_pkg::ALU_SLLV;
          id_pkg::FN_SRLV: aluop_o = id_pkg::ALU_SRLV;
          id_pkg::FN_SRAV: aluop_o = id_pkg::ALU_SRAV;
          id_pkg::FN_SLT:  aluop_o = id_pkg::ALU_SLT;
          id_pkg::FN_SLTU: aluop_o = id_pkg::ALU_SLTU;
          id_pkg::FN_ADD:  aluop_o = id_pkg::ALU_ADD;
          id_pkg::FN_ADDU: aluop_o = id_pkg::ALU_ADDU;
          id_pkg::FN_SUB:  aluop_o = id_pkg::ALU_SUB;
          id_pkg::FN_SUBU: aluop_o = id_pkg::ALU_SUBU;
          id_pkg::FN_JR:   aluop_o = id_pkg::ALU_JR;
          id_pkg::FN_JALR: aluop_o = id_pkg::ALU_JALR;
          default: ;
        endcase
      end
      // constant shifts, rs must be zero
      if (inst_i.r.rs == '0) begin
        case (inst_i.r.funct)
          id_pkg::FN_SLL: aluop_o = id_pkg::ALU_SLL;
          id_pkg::FN_SRL: aluop_o = id_pkg::ALU_SRL;
          id_pkg::FN_SRA: aluop_o = id_pkg::ALU_SRA;
          default: ;
        endcase
      end
      if (aluop_o inside {id_pkg::ALU_SLL, id_pkg::ALU_SRL, id_pkg::ALU_SRA}) begin
        reg2_read_o = 1'b1;
        imm_o       = id_pkg::DATA_W'(inst_i.r.shamt);
      end else if (aluop_o != id_pkg::ALU_NOP) begin
        reg1_read_o = 1'b1;
        reg2_read_o = !(aluop_o inside {id_pkg::ALU_JR, id_pkg::ALU_JALR});
      end
      wreg_o = (aluop_o != id_pkg::ALU_NOP) && (aluop_o != id_pkg::ALU_JR);
    end else begin
      case (inst_i.i.op)
        id_pkg::OP_ORI,
        id_pkg::OP_LUI:   aluop_o = id_pkg::ALU_OR;
        id_pkg::OP_ANDI:  aluop_o = id_pkg::ALU_AND;
        id_pkg::OP_XORI:  aluop_o = id_pkg::ALU_XOR;
        id_pkg::OP_SLTI:  aluop_o = id_pkg::ALU_SLT;
        id_pkg::OP_SLTIU: aluop_o = id_pkg::ALU_SLTU;
        id_pkg::OP_ADDI:  aluop_o = id_pkg::ALU_ADDI;
        id_pkg::OP_ADDIU: aluop_o = id_pkg::ALU_ADDIU;
        id_pkg::OP_J:     aluop_o = id_pkg::ALU_J;
        id_pkg::OP_JAL:   aluop_o = id_pkg::ALU_JAL;
        id_pkg::OP_BEQ:   aluop_o = id_pkg::ALU_BEQ;
        id_pkg::OP_LB:    aluop_o = id_pkg::ALU_LB;
        id_pkg::OP_LW:    aluop_o = id_pkg::ALU_LW;
        id_pkg::OP_SB:    aluop_o = id_pkg::ALU_SB;
        id_pkg::OP_SH:    aluop_o = id_pkg::ALU_SH;
        id_pkg::OP_SW:    aluop_o = id_pkg::ALU_SW;
        default: ;
      endcase
      if (aluop_o != id_pkg::ALU_NOP) begin
        wd_o        = (aluop_o == id_pkg::ALU_JAL) ? id_pkg::LINK_REG : inst_i.i.rt;
        wreg_o      = !(aluop_o inside {id_pkg::ALU_J, id_pkg::ALU_BEQ,
                                        id_pkg::ALU_SB, id_pkg::ALU_SH, id_pkg::ALU_SW});
        reg1_read_o = !(aluop_o inside {id_pkg::ALU_J, id_pkg::ALU_JAL});
        reg2_read_o = aluop_o inside {id_pkg::ALU_BEQ, id_pkg::ALU_SB,
                                      id_pkg::ALU_SH, id_pkg::ALU_SW};
      end
      // immediate forms by opcode
      case (inst_i.i.op)
        id_pkg::OP_LUI:   imm_o = {imm, 16'h0};
        id_pkg::OP_ORI,
        id_pkg::OP_ANDI,
        id_pkg::OP_XORI:  imm_o = {16'h0, imm};
        id_pkg::OP_SLTI,
        id_pkg::OP_SLTIU,
        id_pkg::OP_ADDI,
        id_pkg::OP_ADDIU: imm_o = {{16{imm[15]}}, imm};
        default: ;
      endcase
    end
    invalid_o = (aluop_o == id_pkg::ALU_NOP);
  end

endmodule

// File: id_pkg.sv
package id_pkg;

  localparam int DATA_W     = 32;
  localparam int REG_ADDR_W = 5;
  localparam int REG_NUM    = 32;

  // jal writes its return address here
  localparam logic [REG_ADDR_W-1:0] LINK_REG = 5'd31;

  // grouped by result class, the decoder relies on this order
  typedef enum logic [7:0] {
    ALU_NOP,
    ALU_OR, ALU_AND, ALU_XOR, ALU_NOR,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLLV, ALU_SRLV, ALU_SRAV,
    ALU_SLT, ALU_SLTU, ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU, ALU_ADDI, ALU_ADDIU,
    ALU_J, ALU_JAL, ALU_JR, ALU_JALR, ALU_BEQ,
    ALU_LB, ALU_LW, ALU_SB, ALU_SH, ALU_SW
  } aluop_t;

  typedef enum logic [2:0] {
    SEL_NOP,
    SEL_LOGIC,
    SEL_SHIFT,
    SEL_ARITH,
    SEL_JUMP_BRANCH,
    SEL_LOAD_STORE
  } alusel_t;

  typedef enum logic [5:0] {
    OP_SPECIAL = 6'b000000,
    OP_J       = 6'b000010,
    OP_JAL     = 6'b000011,
    OP_BEQ     = 6'b000100,
    OP_ADDI    = 6'b001000,
    OP_ADDIU   = 6'b001001,
    OP_SLTI    = 6'b001010,
    OP_SLTIU   = 6'b001011,
    OP_ANDI    = 6'b001100,
    OP_ORI     = 6'b001101,
    OP_XORI    = 6'b001110,
    OP_LUI     = 6'b001111,
    OP_LB      = 6'b100000,
    OP_LW      = 6'b100011,
    OP_SB      = 6'b101000,
    OP_SH      = 6'b101001,
    OP_SW      = 6'b101011
  } op_e;

  typedef enum logic [5:0] {
    FN_SLL  = 6'b000000,
    FN_SRL  = 6'b000010,
    FN_SRA  = 6'b000011,
    FN_SLLV = 6'b000100,
    FN_SRLV = 6'b000110,
    FN_SRAV = 6'b000111,
    FN_JR   = 6'b001000,
    FN_JALR = 6'b001001,
    FN_ADD  = 6'b100000,
    FN_ADDU = 6'b100001,
    FN_SUB  = 6'b100010,
    FN_SUBU = 6'b100011,
    FN_AND  = 6'b100100,
    FN_OR   = 6'b100101,
    FN_XOR  = 6'b100110,
    FN_NOR  = 6'b100111,
    FN_SLT  = 6'b101010,
    FN_SLTU = 6'b101011
  } funct_e;

  // one instruction word seen as r, i or j format
  typedef union packed {
    struct packed {
      op_e                   op;
      logic [REG_ADDR_W-1:0] rs;
      logic [REG_ADDR_W-1:0] rt;
      logic [REG_ADDR_W-1:0] rd;
      logic [4:0]            shamt;
      funct_e                funct;
    } r;
    struct packed {
      op_e                   op;
      logic [REG_ADDR_W-1:0] rs;
      logic [REG_ADDR_W-1:0] rt;
      logic [15:0]           imm;
    } i;
    struct packed {
      op_e                   op;
      logic [25:0]           target;
    } j;
  } inst_t;

  function automatic logic is_load(aluop_t op);
    return (op == ALU_LB) || (op == ALU_LW);
  endfunction

endpackage
